// File: logic/exec_defines.svh
/*
 * width and size constants for the execute slice
 * pulled in by the package and any module that sizes storage
 */
`ifndef EXEC_DEFINES_SVH
`define EXEC_DEFINES_SVH

// architectural register count, x0 included
`define EXEC_NUM_REGS 32

// data path width, rv32
`define EXEC_XLEN 32

// bits needed to index the register bank
`define EXEC_IDX_W 5

// width of the major opcode field
`define EXEC_OPC_W 7

`endif

// File: logic/exec_pkg.sv
/*
 * shared types of the execute slice
 * referenced by scoped name, exec_pkg::word_t and so on
 */
`include "exec_defines.svh"

package exec_pkg;

    typedef logic [`EXEC_XLEN-1:0]  word_t;     // data or instruction word
    typedef logic [`EXEC_IDX_W-1:0] reg_idx_t;  // register index

    // operations the alu knows about
    typedef enum logic [3:0] {
        ADD    = 4'd0,
        SUB    = 4'd1,
        SLL    = 4'd2,
        SLT    = 4'd3,
        SLTU   = 4'd4,
        XOR    = 4'd5,
        SRL    = 4'd6,
        SRA    = 4'd7,
        OR     = 4'd8,
        AND    = 4'd9,
        PASS_B = 4'd10     // lui, operand b straight through
    } alu_op_t;

    // major opcodes handled here, everything else is illegal
    typedef enum logic [`EXEC_OPC_W-1:0] {
        LUI    = 7'b0110111,
        OP_IMM = 7'b0010011,
        OP     = 7'b0110011
    } opcode_t;

    // issue stage occupancy
    typedef enum logic {
        IDLE  = 1'b0,   // execute stage empty
        ISSUE = 1'b1    // decoded instr held for execute
    } dec_state_t;

endpackage

// File: logic/exec_ctrl_if.sv
/*
 * decoded control bundle, decoder drives it, regbank and alu consume it
 */
`timescale 1ns/10ps

interface exec_ctrl_if;

    exec_pkg::reg_idx_t rs1;        // source a
    exec_pkg::reg_idx_t rs2;        // source b
    exec_pkg::reg_idx_t rd;         // destination
    exec_pkg::alu_op_t  alu_op;
    exec_pkg::word_t    imm;        // i or u immediate, already formed
    logic               use_imm;    // operand b from imm
    logic               zero_a;     // operand a forced to 0
    logic               exec_valid; // legal instr in execute

    // decoder side
    modport ctrl (
        output rs1, rs2, rd, alu_op, imm, use_imm, zero_a, exec_valid
    );

    // datapath side
    modport dp (
        input rs1, rs2, rd, alu_op, imm, use_imm, zero_a, exec_valid
    );

endinterface

// File: logic/regbank.sv
/*
 * 32 x 32 register bank, two combinational reads and one write
 * x0 is never written so it always reads zero
 */
`timescale 1ns/10ps
`include "exec_defines.svh"

module regbank (
    input  logic               clk,
    input  logic               reset_n,

    exec_ctrl_if.dp            ctrl,       // read indices come from rs1/rs2

    input  logic               wr_en_i,
    input  exec_pkg::reg_idx_t wr_idx_i,
    input  exec_pkg::word_t    wr_data_i,
    output exec_pkg::word_t    rdata1_o,
    output exec_pkg::word_t    rdata2_o
);

    exec_pkg::word_t regs [`EXEC_NUM_REGS];
    logic            wr_live;      // write that will really land

    assign wr_live = wr_en_i && (wr_idx_i != '0);

    // a write presented this cycle is already visible to the reader,
    // so an instr issued right behind its producer sees the new value
    assign rdata1_o = (wr_live && wr_idx_i == ctrl.rs1) ? wr_data_i : regs[ctrl.rs1];
    assign rdata2_o = (wr_live && wr_idx_i == ctrl.rs2) ? wr_data_i : regs[ctrl.rs2];

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < `EXEC_NUM_REGS; i++) begin
                regs[i] <= '0;      // everything reads zero after reset
            end
        end else if (wr_live) begin
            regs[wr_idx_i] <= wr_data_i;
        end
    end

endmodule

// File: logic/alu.sv
/*
 * rv32i integer alu with a result register
 * the registered outputs are the write-back to the bank and the top level
 */
`timescale 1ns/10ps

module alu (
    input  logic               clk,
    input  logic               reset_n,

    exec_ctrl_if.dp            ctrl,

    input  exec_pkg::word_t    rdata1_i,   // rs1 data
    input  exec_pkg::word_t    rdata2_i,   // rs2 data
    output logic               wr_en_o,
    output exec_pkg::reg_idx_t wr_idx_o,
    output exec_pkg::word_t    wr_data_o
);

    exec_pkg::word_t op_a;
    exec_pkg::word_t op_b;
    exec_pkg::word_t result;
    logic [4:0]      shamt;            // only low 5 bits of b count

    assign op_a  = ctrl.zero_a  ? '0 : rdata1_i;    // lui path
    assign op_b  = ctrl.use_imm ? ctrl.imm : rdata2_i;
    assign shamt = op_b[4:0];

    always_comb begin
        case (ctrl.alu_op)
            exec_pkg::ADD:    result = op_a + op_b;
            exec_pkg::SUB:    result = op_a - op_b;    // wraps mod 2^32
            exec_pkg::SLL:    result = op_a << shamt;
            exec_pkg::SLT:    result = ($signed(op_a) < $signed(op_b)) ? 32'd1 : 32'd0;
            exec_pkg::SLTU:   result = (op_a < op_b) ? 32'd1 : 32'd0;
            exec_pkg::XOR:    result = op_a ^ op_b;
            exec_pkg::SRL:    result = op_a >> shamt;
            exec_pkg::SRA:    result = $signed(op_a) >>> shamt;   // keeps sign
            exec_pkg::OR:     result = op_a | op_b;
            exec_pkg::AND:    result = op_a & op_b;
            exec_pkg::PASS_B: result = op_b;
            default:          result = '0;
        endcase
    end

    // write enable, one edge behind exec_valid
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_en_o <= 1'b0;
        end else begin
            wr_en_o <= ctrl.exec_valid;
        end
    end

    // payload only moves with a valid instr
    always_ff @(posedge clk) begin
        if (ctrl.exec_valid) begin
            wr_idx_o  <= ctrl.rd;
            wr_data_o <= result;
        end
    end

endmodule

// File: logic/decoder.sv
/*
 * rv32i decode for lui, op-imm and op, one word per valid strobe
 * holds the decoded instr for execute, flags illegal words at write-back time
 */
`timescale 1ns/10ps

module decoder (
    input  logic            clk,
    input  logic            reset_n,

    input  exec_pkg::word_t instr_i,
    input  logic            instr_valid_i,   // one cycle strobe

    exec_ctrl_if.ctrl       ctrl,
    output logic            illegal_o        // aligned with wb pulse
);

    exec_pkg::opcode_t    opcode;
    logic [2:0]           funct3;
    logic [6:0]           funct7;
    exec_pkg::word_t      imm_i;      // sign extended 12 bit
    exec_pkg::word_t      imm_u;      // upper 20, low 12 zero

    exec_pkg::alu_op_t    dec_op;
    exec_pkg::word_t      dec_imm;
    logic                 dec_use_imm;
    logic                 dec_zero_a;
    logic                 dec_legal;

    exec_pkg::dec_state_t state;
    logic                 ill_q;      // illegal word now in execute slot

    // field split
    assign opcode = exec_pkg::opcode_t'(instr_i[6:0]);
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];
    assign imm_i  = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_u  = {instr_i[31:12], 12'b0};

    always_comb begin
        dec_op      = exec_pkg::ADD;
        dec_imm     = imm_i;
        dec_use_imm = 1'b0;
        dec_zero_a  = 1'b0;
        dec_legal   = 1'b1;
        case (opcode)
            exec_pkg::LUI: begin
                dec_op      = exec_pkg::PASS_B;
                dec_imm     = imm_u;
                dec_use_imm = 1'b1;
                dec_zero_a  = 1'b1;
            end
            exec_pkg::OP_IMM: begin
                dec_use_imm = 1'b1;
                case (funct3)
                    3'b000: dec_op = exec_pkg::ADD;
                    3'b010: dec_op = exec_pkg::SLT;
                    3'b011: dec_op = exec_pkg::SLTU;
                    3'b100: dec_op = exec_pkg::XOR;
                    3'b110: dec_op = exec_pkg::OR;
                    3'b111: dec_op = exec_pkg::AND;
                    3'b001: begin                      // slli, funct7 must be 0
                        dec_op    = exec_pkg::SLL;
                        dec_legal = (funct7 == 7'b0000000);
                    end
                    default: begin                     // 101, srli or srai
                        dec_op    = funct7[5] ? exec_pkg::SRA : exec_pkg::SRL;
                        dec_legal = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
                    end
                endcase
            end
            exec_pkg::OP: begin
                if (funct7 == 7'b0000000) begin
                    case (funct3)
                        3'b000:  dec_op = exec_pkg::ADD;
                        3'b001:  dec_op = exec_pkg::SLL;
                        3'b010:  dec_op = exec_pkg::SLT;
                        3'b011:  dec_op = exec_pkg::SLTU;
                        3'b100:  dec_op = exec_pkg::XOR;
                        3'b101:  dec_op = exec_pkg::SRL;
                        3'b110:  dec_op = exec_pkg::OR;
                        default: dec_op = exec_pkg::AND;
                    endcase
                end else if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
                    dec_op = exec_pkg::SUB;
                end else if (funct7 == 7'b0100000 && funct3 == 3'b101) begin
                    dec_op = exec_pkg::SRA;
                end else begin
                    dec_legal = 1'b0;   // unused funct pattern
                end
            end
            default: dec_legal = 1'b0;  // opcode outside the slice
        endcase
    end

    // issue state and illegal pipe
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state     <= exec_pkg::IDLE;
            ill_q     <= 1'b0;
            illegal_o <= 1'b0;
        end else begin
            state     <= (instr_valid_i && dec_legal) ? exec_pkg::ISSUE : exec_pkg::IDLE;
            ill_q     <= instr_valid_i && !dec_legal;
            illegal_o <= ill_q;     // one more edge, lines up with wb
        end
    end

    assign ctrl.exec_valid = (state == exec_pkg::ISSUE);

    // decoded payload, captured with every strobe
    always_ff @(posedge clk) begin
        if (instr_valid_i) begin
            ctrl.rs1     <= instr_i[19:15];
            ctrl.rs2     <= instr_i[24:20];
            ctrl.rd      <= instr_i[11:7];
            ctrl.alu_op  <= dec_op;
            ctrl.imm     <= dec_imm;
            ctrl.use_imm <= dec_use_imm;
            ctrl.zero_a  <= dec_zero_a;
        end
    end

endmodule

// File: logic/exec_unit.sv
/*
 * top of the rv32i execute slice, decoder -> regbank -> alu
 * fixed 2 cycle latency from instr_valid_i to wb_valid_o or illegal_o
 */
`timescale 1ns/10ps

module exec_unit (
    input  logic               clk,
    input  logic               reset_n,

    input  exec_pkg::word_t    instr_i,
    input  logic               instr_valid_i,

    output logic               wb_valid_o,   // result written (x0 reported too)
    output exec_pkg::reg_idx_t wb_rd_o,
    output exec_pkg::word_t    wb_data_o,
    output logic               illegal_o     // undecodable word, no write
);

    exec_ctrl_if ctrl ();

    exec_pkg::word_t    rdata1;
    exec_pkg::word_t    rdata2;
    logic               wr_en;       // registered alu write-back
    exec_pkg::reg_idx_t wr_idx;
    exec_pkg::word_t    wr_data;

    decoder u_decoder (
        .clk           (clk),
        .reset_n       (reset_n),
        .instr_i       (instr_i),
        .instr_valid_i (instr_valid_i),
        .ctrl          (ctrl.ctrl),
        .illegal_o     (illegal_o)
    );

    regbank u_regbank (
        .clk       (clk),
        .reset_n   (reset_n),
        .ctrl      (ctrl.dp),
        .wr_en_i   (wr_en),
        .wr_idx_i  (wr_idx),
        .wr_data_i (wr_data),
        .rdata1_o  (rdata1),
        .rdata2_o  (rdata2)
    );

    alu u_alu (
        .clk       (clk),
        .reset_n   (reset_n),
        .ctrl      (ctrl.dp),
        .rdata1_i  (rdata1),
        .rdata2_i  (rdata2),
        .wr_en_o   (wr_en),
        .wr_idx_o  (wr_idx),
        .wr_data_o (wr_data)
    );

    // write-back leaves the slice as is
    assign wb_valid_o = wr_en;
    assign wb_rd_o    = wr_idx;
    assign wb_data_o  = wr_data;

endmodule

// File: tests/clock_gen.sv
/*
 * testbench clock and reset source
 * free running clock, reset_n low for RESET_CYCLES rising edges
 */
`timescale 1ns/10ps

module clock_gen #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 16,
    parameter int RELEASE_NS   = 2     // release just after an edge
) (
    output logic clk_o,
    output logic reset_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // hold reset, then let go away from the sampling edge
    initial begin
        reset_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #(RELEASE_NS) reset_n_o = 1'b1;
    end

endmodule

// File: tests/tb_exec_unit.sv
/*
 * testbench for the execute slice, drives words from tests/exec_stimulus.txt
 * and checks every write-back or illegal pulse against the file's expectations
 */
`timescale 1ns/10ps
`include "exec_defines.svh"

module tb_exec_unit;

    localparam int    RESET_CYCLES = 16;
    localparam int    DRIVE_DELAY  = 2;     // ns after the rising edge
    localparam string STIM_FILE    = "tests/exec_stimulus.txt";

    logic               clk;
    logic               reset_n;
    exec_pkg::word_t    instr;
    logic               instr_valid;
    logic               wb_valid;
    exec_pkg::reg_idx_t wb_rd;
    exec_pkg::word_t    wb_data;
    logic               illegal;

    // one entry per stimulus line
    exec_pkg::word_t    stim_instr [$];
    logic               stim_ill   [$];
    exec_pkg::reg_idx_t stim_rd    [$];
    exec_pkg::word_t    stim_res   [$];
    logic               stim_gap   [$];    // idle cycles follow this word
    string              stim_name  [$];

    int pending [$];       // lines issued, answer not seen yet
    int due     [$];       // edge count at which each answer shows
    int cycle   = 0;       // rising edges so far
    int checked = 0;
    int seed    = 44526;   // gap lengths only
    bit loaded  = 1'b0;

    clock_gen #(
        .PERIOD_NS    (20),
        .RESET_CYCLES (RESET_CYCLES),
        .RELEASE_NS   (DRIVE_DELAY)
    ) u_clock_gen (
        .clk_o     (clk),
        .reset_n_o (reset_n)
    );

    exec_unit UUT (
        .clk           (clk),
        .reset_n       (reset_n),
        .instr_i       (instr),
        .instr_valid_i (instr_valid),
        .wb_valid_o    (wb_valid),
        .wb_rd_o       (wb_rd),
        .wb_data_o     (wb_data),
        .illegal_o     (illegal)
    );

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_word(input string name, input exec_pkg::word_t expected,
                              input exec_pkg::word_t actual);
        if (actual !== expected) begin
            abort_run($sformatf("[ERROR] %s: expected 0x%08h, actual 0x%08h",
                                name, expected, actual));
        end
    endtask

    task automatic check_idx(input string name, input exec_pkg::reg_idx_t expected,
                             input exec_pkg::reg_idx_t actual);
        if (actual !== expected) begin
            abort_run($sformatf("[ERROR] %s: expected x%0d, actual x%0d",
                                name, expected, actual));
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            abort_run($sformatf("[ERROR] %s: expected %0b, actual %0b",
                                name, expected, actual));
        end
    endtask

    // '#' lines and blank lines are skipped
    task automatic load_stimulus();
        int              fd;
        int              n;
        int              ill;
        int              rd;
        int              gap;
        string           line;
        string           name;
        exec_pkg::word_t word;
        exec_pkg::word_t res;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) abort_run({"cannot open stimulus file ", STIM_FILE});
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n == 0 || line.len() < 2 || line.getc(0) == 8'h23) continue;  // 0x23 is '#'
            n = $sscanf(line, "%h %d %d %h %d %s", word, ill, rd, res, gap, name);
            if (n != 6) abort_run({"malformed stimulus line: ", line});
            if (rd < 0 || rd >= `EXEC_NUM_REGS) abort_run({"register out of range: ", line});
            stim_instr.push_back(word);
            stim_ill.push_back(ill != 0);
            stim_rd.push_back(exec_pkg::reg_idx_t'(rd));
            stim_res.push_back(res);
            stim_gap.push_back(gap != 0);
            stim_name.push_back(name);
        end
        $fclose(fd);
        if (stim_instr.size() == 0) abort_run("stimulus file holds no instructions");
    endtask

    // time base for the latency check
    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // outputs settle after the rising edge, look at them mid cycle
    always @(negedge clk) begin : result_monitor
        int    idx;
        int    due_cycle;
        string name;
        if (wb_valid === 1'b1 || illegal === 1'b1) begin
            if (pending.size() == 0) begin
                abort_run("DUT produced a result with no instruction outstanding");
            end else begin
                idx       = pending.pop_front();
                due_cycle = due.pop_front();
                name      = stim_name[idx];
                if (cycle != due_cycle) begin      // 2 cycles from the sampling edge
                    abort_run($sformatf("[ERROR] %s latency: expected cycle %0d, actual cycle %0d",
                                        name, due_cycle, cycle));
                end
                check_flag({name, " illegal_o"}, stim_ill[idx], illegal);
                check_flag({name, " wb_valid_o"}, !stim_ill[idx], wb_valid);
                if (!stim_ill[idx]) begin          // illegal words carry no payload
                    check_idx({name, " wb_rd_o"}, stim_rd[idx], wb_rd);
                    check_word({name, " wb_data_o"}, stim_res[idx], wb_data);
                end
                checked++;
            end
        end
    end

    initial begin : main_flow
        int gap_len;
        instr       = '0;
        instr_valid = 1'b0;
        load_stimulus();
        loaded = 1'b1;
        wait (reset_n === 1'b1);
        for (int i = 0; i < stim_instr.size(); i++) begin
            @(posedge clk);
            #(DRIVE_DELAY);
            instr       = stim_instr[i];
            instr_valid = 1'b1;
            pending.push_back(i);
            due.push_back(cycle + 2);   // sampled next edge, answer one edge later
            if (stim_gap[i]) begin
                gap_len = 1 + (($random(seed) & 32'h7fff_ffff) % 3);   // 1..3 idle
                repeat (gap_len) begin
                    @(posedge clk);
                    #(DRIVE_DELAY);
                    instr_valid = 1'b0;
                    instr       = '0;
                end
            end
        end
        @(posedge clk);
        #(DRIVE_DELAY);
        instr_valid = 1'b0;
        instr       = '0;
        // fixed 2 cycle latency, a few edges is plenty
        for (int c = 0; c < 4 && pending.size() != 0; c++) @(negedge clk);
        repeat (2) @(negedge clk);                 // catch stray pulses
        if (pending.size() != 0) begin
            abort_run($sformatf("%0d instructions never produced a result", pending.size()));
        end else begin
            $display("%0d results checked", checked);
            $display("Simulation passed");
            $finish;
        end
    end

    // reset, then at most 4 cycles per line, then drain slack
    initial begin : watchdog
        int limit;
        wait (loaded);
        limit = RESET_CYCLES + 4 * stim_instr.size() + 20;
        repeat (limit) @(posedge clk);
        abort_run($sformatf("timeout after %0d cycles, the run did not finish", limit));
    end

endmodule

// File: compile.f
+incdir+logic
logic/exec_pkg.sv
logic/exec_ctrl_if.sv
logic/regbank.sv
logic/alu.sv
logic/decoder.sv
logic/exec_unit.sv
tests/clock_gen.sv
tests/tb_exec_unit.sv

// File: Makefile
# Verilator flow for the execute slice
# run from the project root, the testbench opens tests/exec_stimulus.txt

VERILATOR ?= verilator
TOP       ?= tb_exec_unit
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
TIMESCALE ?= 1ns/10ps
VFLAGS    ?= --binary --timing -j 0
SIM_ARGS  ?=

sim:
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
		-f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS)

clean:
	rm -rf $(BUILD_DIR)

.PHONY: sim clean

// File: tests/exec_stimulus.txt
# instr(hex) illegal(0/1) rd(dec) result(hex) gap(0/1, idle cycles follow) name
# illegal lines carry rd and result as 0, later lines read the targets back
# empty bank after reset
002081b3 0 3  00000000 1 add_after_reset
# constants from lui and addi, back to back dependencies
123450b7 0 1  12345000 0 lui_x1
67808093 0 1  12345678 0 addi_x1_dep
fffff137 0 2  fffff000 1 lui_x2
fff10113 0 2  ffffefff 0 addi_x2_neg
ffb00213 0 4  fffffffb 0 addi_x4_neg5
00300293 0 5  00000003 1 addi_x5_3
# register-register ops
00208333 0 6  12344677 0 add
404283b3 0 7  00000008 0 sub
40500433 0 8  fffffffd 0 sub_wrap
005224b3 0 9  00000001 1 slt_neg
00523533 0 10 00000000 0 sltu_neg
005095b3 0 11 91a2b3c0 0 sll
00525633 0 12 1fffffff 0 srl_neg
405256b3 0 13 ffffffff 1 sra_neg
0020c733 0 14 edcbb987 0 xor
0050e7b3 0 15 1234567b 0 or
0020f833 0 16 12344678 0 and
008298b3 0 17 60000000 1 sll_masked
# register-immediate ops
fff22913 0 18 00000001 0 slti
fff2b993 0 19 00000001 0 sltiu_max
00423a13 0 20 00000000 1 sltiu_neg
fff0ca93 0 21 edcba987 0 xori_not
7ff06b13 0 22 000007ff 0 ori
0f00fb93 0 23 00000070 0 andi
00409c13 0 24 23456780 1 slli
01c25c93 0 25 0000000f 0 srli_neg
40125d13 0 26 fffffffd 0 srai_neg
4040dd93 0 27 01234567 1 srai_pos
# x0 write shows on the port but is not stored
00008013 0 0  12345678 0 addi_x0
00000e33 0 28 00000000 1 read_x0
# load opcode, mul funct7, slli with funct7 set
00002083 1 0  00000000 0 load_opcode
02208333 1 0  00000000 0 mul_funct7
40109293 1 0  00000000 1 slli_funct7
00008e93 0 29 12345678 0 x1_kept
00530f33 0 30 1234467a 1 x6_x5_kept
# most negative i-type immediate
80000fb7 0 31 80000000 0 lui_x31
800f8f93 0 31 7ffff800 0 addi_min_imm
